// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tile_mem_router_tb
FILELIST  ?= tile_mem_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/cfg_slice.sv ====
/*
 * Configuration register slice
 * Holds the core freeze bit and the boot PC, one response in flight
 */

`include "tile_mem_defines.svh"

module cfg_slice
  import tile_mem_pkg::*;
  (
    input  logic                    clk_i
    , input  logic                  rst_n_i
    , mem_msg_if.dev                bus
    , output logic                  freeze_o
    , output logic [`TILE_ADDR_W-1:0] boot_pc_o
  );

  logic                    freeze_r;
  logic [`TILE_ADDR_W-1:0] boot_pc_r;
  logic                    resp_v_r;
  mem_msg_s                resp_r;
  logic                    accept;
  logic                    is_wr;
  logic [`TILE_DATA_W-1:0] rd_data;

  assign bus.cmd_ready = ~resp_v_r;
  assign accept        = bus.cmd_v & bus.cmd_ready;
  assign is_wr         = (bus.cmd.opcode == e_mem_wr);

  always_comb
  begin
    case (bus.cmd.addr.loc.ofs)
      `CFG_FREEZE_OFS:  rd_data = {{(`TILE_DATA_W-1){1'b0}}, freeze_r};
      `CFG_BOOT_PC_OFS: rd_data = {{(`TILE_DATA_W-`TILE_ADDR_W){1'b0}}, boot_pc_r};
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r  <= 1'b1;
      boot_pc_r <= `BOOT_PC_RESET;
    end
    else if (accept && is_wr)
    begin
      if (bus.cmd.addr.loc.ofs == `CFG_FREEZE_OFS)
        freeze_r <= bus.cmd.data[0];
      if (bus.cmd.addr.loc.ofs == `CFG_BOOT_PC_OFS)
        boot_pc_r <= bus.cmd.data[`TILE_ADDR_W-1:0];
    end
  end

  // One-entry response buffer
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (bus.resp_yumi)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: bus.cmd.opcode, addr: bus.cmd.addr,
                  data: is_wr ? '0 : rd_data};
  end

  assign bus.resp_v = resp_v_r;
  assign bus.resp   = resp_r;
  assign freeze_o   = freeze_r;
  assign boot_pc_o  = boot_pc_r;

endmodule

// ==== hdl/clint_slice.sv ====
/*
 * Core-local interruptor slice
 * Machine timer, timer compare and software interrupt pending bit,
 * one response in flight
 */

`include "tile_mem_defines.svh"

module clint_slice
  import tile_mem_pkg::*;
  (
    input  logic    clk_i
    , input  logic  rst_n_i
    , mem_msg_if.dev bus
    , input  logic  rtc_tick_i
    , output logic  timer_irq_o
    , output logic  software_irq_o
  );

  logic [`TILE_DATA_W-1:0] mtime_r;
  logic [`TILE_DATA_W-1:0] mtimecmp_r;
  logic                    msip_r;
  logic                    timer_irq_r;
  logic                    resp_v_r;
  mem_msg_s                resp_r;
  logic                    accept;
  logic                    is_wr;
  logic                    wr_msip;
  logic                    wr_mtimecmp;
  logic                    wr_mtime;
  logic [`TILE_DATA_W-1:0] rd_data;

  assign bus.cmd_ready = ~resp_v_r;
  assign accept        = bus.cmd_v & bus.cmd_ready;
  assign is_wr         = (bus.cmd.opcode == e_mem_wr);

  assign wr_msip     = accept & is_wr & (bus.cmd.addr.loc.ofs == `CLINT_MSIP_OFS);
  assign wr_mtimecmp = accept & is_wr & (bus.cmd.addr.loc.ofs == `CLINT_MTIMECMP_OFS);
  assign wr_mtime    = accept & is_wr & (bus.cmd.addr.loc.ofs == `CLINT_MTIME_OFS);

  // Reads see the registers before this cycle's update
  always_comb
  begin
    case (bus.cmd.addr.loc.ofs)
      `CLINT_MSIP_OFS:     rd_data = {{(`TILE_DATA_W-1){1'b0}}, msip_r};
      `CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      `CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:             rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
    end
    else
    begin
      // a write beats the tick
      if (wr_mtime)
        mtime_r <= bus.cmd.data;
      else if (rtc_tick_i)
        mtime_r <= mtime_r + 1'b1;
      if (wr_mtimecmp)
        mtimecmp_r <= bus.cmd.data;
      if (wr_msip)
        msip_r <= bus.cmd.data[0];
      timer_irq_r <= (mtime_r >= mtimecmp_r);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (bus.resp_yumi)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_r <= '{opcode: bus.cmd.opcode, addr: bus.cmd.addr,
                  data: is_wr ? '0 : rd_data};
  end

  assign bus.resp_v     = resp_v_r;
  assign bus.resp       = resp_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

// ==== hdl/mem_cmd_decode.sv ====
/*
 * Local memory map decoder
 * Sends each command to the cache path, the config slice or the CLINT,
 * and drops unmapped local commands
 */

`include "tile_mem_defines.svh"

module mem_cmd_decode
  import tile_mem_pkg::*;
  (
    input  logic           cmd_v_i
    , input  mem_msg_s     cmd_i
    , output logic         cmd_ready_o

    , mem_msg_if.cmd_src   cache
    , mem_msg_if.cmd_src   cfg
    , mem_msg_if.cmd_src   clint
  );

  logic              local_cmd;
  logic [`DEV_W-1:0] dev_id;

  assign local_cmd = (cmd_i.addr.raw < `LOCAL_LIMIT);
  assign dev_id    = cmd_i.addr.loc.dev;

  // Upstream only sees ready when every target can take the command
  assign cmd_ready_o = cache.cmd_ready & cfg.cmd_ready & clint.cmd_ready;

  assign cache.cmd = cmd_i;
  assign cfg.cmd   = cmd_i;
  assign clint.cmd = cmd_i;

  // Each valid waits on the other two targets, so a target never
  // takes a command that upstream does not see accepted
  assign cache.cmd_v = cmd_v_i & ~local_cmd
                       & cfg.cmd_ready & clint.cmd_ready;
  assign cfg.cmd_v   = cmd_v_i & local_cmd & (dev_id == `CFG_DEV_ID)
                       & cache.cmd_ready & clint.cmd_ready;
  assign clint.cmd_v = cmd_v_i & local_cmd & (dev_id == `CLINT_DEV_ID)
                       & cache.cmd_ready & cfg.cmd_ready;

endmodule

// ==== hdl/mem_msg_if.sv ====
/*
 * Memory message link to one target
 * Command side is valid/ready, response side is valid/yumi
 */

interface mem_msg_if
  import tile_mem_pkg::*;
  ();

  mem_msg_s cmd;
  logic     cmd_v;
  logic     cmd_ready;

  mem_msg_s resp;
  logic     resp_v;
  logic     resp_yumi;

  modport cmd_src (output cmd, output cmd_v, input cmd_ready);

  modport dev (input cmd, input cmd_v, output cmd_ready,
               output resp, output resp_v, input resp_yumi);

  modport resp_sink (input resp, input resp_v, output resp_yumi);

endinterface

// ==== hdl/mem_resp_arb.sv ====
/*
 * Response merge
 * Fixed priority: cache path, then config slice, then CLINT
 */

module mem_resp_arb
  import tile_mem_pkg::*;
  (
    mem_msg_if.resp_sink cache
    , mem_msg_if.resp_sink cfg
    , mem_msg_if.resp_sink clint

    , output logic     resp_v_o
    , output mem_msg_s resp_o
    , input  logic     resp_yumi_i
  );

  logic cache_gnt;
  logic cfg_gnt;
  logic clint_gnt;

  assign cache_gnt = cache.resp_v;
  assign cfg_gnt   = cfg.resp_v & ~cache.resp_v;
  assign clint_gnt = clint.resp_v & ~cfg.resp_v & ~cache.resp_v;

  assign resp_v_o = cache.resp_v | cfg.resp_v | clint.resp_v;

  always_comb
  begin
    if (cache_gnt)
      resp_o = cache.resp;
    else if (cfg_gnt)
      resp_o = cfg.resp;
    else
      resp_o = clint.resp;
  end

  // Only the granted source sees the acknowledge
  assign cache.resp_yumi = resp_yumi_i & cache_gnt;
  assign cfg.resp_yumi   = resp_yumi_i & cfg_gnt;
  assign clint.resp_yumi = resp_yumi_i & clint_gnt;

endmodule

// ==== hdl/tile_mem_defines.svh ====
/*
 * Tile local memory map constants
 * Widths, the cacheable boundary, device numbers and register offsets
 */

`ifndef TILE_MEM_DEFINES_SVH
`define TILE_MEM_DEFINES_SVH

`define TILE_ADDR_W 32
`define TILE_DATA_W 64

// Lowest cacheable address
`define LOCAL_LIMIT 32'h8000_0000

`define DEV_W        4
`define CLINT_DEV_ID 4'd1
`define CFG_DEV_ID   4'd2

`define CFG_FREEZE_OFS     20'h0
`define CFG_BOOT_PC_OFS    20'h8
`define CLINT_MSIP_OFS     20'h0
`define CLINT_MTIMECMP_OFS 20'h4000
`define CLINT_MTIME_OFS    20'hBFF8

`define BOOT_PC_RESET 32'h8000_0000

`endif

// ==== hdl/tile_mem_pkg.sv ====
/*
 * Tile memory message types
 * Opcode, the two views of a physical address and the message itself
 */

`include "tile_mem_defines.svh"

package tile_mem_pkg;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_opcode_e;

  // Local view of an address below the cacheable boundary
  typedef struct packed
  {
    logic              region;
    logic [6:0]        rsvd;
    logic [`DEV_W-1:0] dev;
    logic [19:0]       ofs;
  } tile_local_addr_s;

  typedef union packed
  {
    logic [`TILE_ADDR_W-1:0] raw;
    tile_local_addr_s        loc;
  } tile_addr_u;

  typedef struct packed
  {
    mem_opcode_e             opcode;
    tile_addr_u              addr;
    logic [`TILE_DATA_W-1:0] data;
  } mem_msg_s;

endpackage

// ==== hdl/tile_mem_router.sv ====
/*
 * Tile local memory-map router
 * Steers coherence engine memory commands to the L2 cache path,
 * the config slice or the CLINT, and merges their responses
 */

`include "tile_mem_defines.svh"

module tile_mem_router
  import tile_mem_pkg::*;
  (
    input  logic                      clk_i
    , input  logic                    rst_n_i

    , input  logic                    mem_cmd_v_i
    , input  mem_opcode_e             mem_cmd_opcode_i
    , input  logic [`TILE_ADDR_W-1:0] mem_cmd_addr_i
    , input  logic [`TILE_DATA_W-1:0] mem_cmd_data_i
    , output logic                    mem_cmd_ready_o

    , output logic                    mem_resp_v_o
    , output mem_opcode_e             mem_resp_opcode_o
    , output logic [`TILE_ADDR_W-1:0] mem_resp_addr_o
    , output logic [`TILE_DATA_W-1:0] mem_resp_data_o
    , input  logic                    mem_resp_yumi_i

    // L2 cache path
    , output logic                    cache_cmd_v_o
    , output mem_opcode_e             cache_cmd_opcode_o
    , output logic [`TILE_ADDR_W-1:0] cache_cmd_addr_o
    , output logic [`TILE_DATA_W-1:0] cache_cmd_data_o
    , input  logic                    cache_cmd_ready_i
    , input  logic                    cache_resp_v_i
    , input  mem_opcode_e             cache_resp_opcode_i
    , input  logic [`TILE_ADDR_W-1:0] cache_resp_addr_i
    , input  logic [`TILE_DATA_W-1:0] cache_resp_data_i
    , output logic                    cache_resp_yumi_o

    , output logic                    freeze_o
    , output logic [`TILE_ADDR_W-1:0] boot_pc_o
    , input  logic                    rtc_tick_i
    , output logic                    timer_irq_o
    , output logic                    software_irq_o
  );

  mem_msg_s mem_cmd_li;
  mem_msg_s mem_resp_lo;

  mem_msg_if cache_if ();
  mem_msg_if cfg_if ();
  mem_msg_if clint_if ();

  assign mem_cmd_li = '{opcode: mem_cmd_opcode_i, addr: mem_cmd_addr_i,
                        data: mem_cmd_data_i};

  mem_cmd_decode decode
    (.cmd_v_i(mem_cmd_v_i)
     ,.cmd_i(mem_cmd_li)
     ,.cmd_ready_o(mem_cmd_ready_o)
     ,.cache(cache_if.cmd_src)
     ,.cfg(cfg_if.cmd_src)
     ,.clint(clint_if.cmd_src)
     );

  cfg_slice cfg
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.bus(cfg_if.dev)
     ,.freeze_o(freeze_o)
     ,.boot_pc_o(boot_pc_o)
     );

  clint_slice clint
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.bus(clint_if.dev)
     ,.rtc_tick_i(rtc_tick_i)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  // Device side of the cache link is the external L2 path
  assign cache_cmd_v_o      = cache_if.cmd_v;
  assign cache_cmd_opcode_o = cache_if.cmd.opcode;
  assign cache_cmd_addr_o   = cache_if.cmd.addr.raw;
  assign cache_cmd_data_o   = cache_if.cmd.data;
  assign cache_if.cmd_ready = cache_cmd_ready_i;
  assign cache_if.resp_v    = cache_resp_v_i;
  assign cache_if.resp      = '{opcode: cache_resp_opcode_i, addr: cache_resp_addr_i,
                                data: cache_resp_data_i};
  assign cache_resp_yumi_o  = cache_if.resp_yumi;

  mem_resp_arb resp_arb
    (.cache(cache_if.resp_sink)
     ,.cfg(cfg_if.resp_sink)
     ,.clint(clint_if.resp_sink)
     ,.resp_v_o(mem_resp_v_o)
     ,.resp_o(mem_resp_lo)
     ,.resp_yumi_i(mem_resp_yumi_i)
     );

  assign mem_resp_opcode_o = mem_resp_lo.opcode;
  assign mem_resp_addr_o   = mem_resp_lo.addr.raw;
  assign mem_resp_data_o   = mem_resp_lo.data;

endmodule

// ==== tile_mem_router.f ====
+incdir+hdl
hdl/tile_mem_pkg.sv
hdl/mem_msg_if.sv
hdl/mem_cmd_decode.sv
hdl/cfg_slice.sv
hdl/clint_slice.sv
hdl/mem_resp_arb.sv
hdl/tile_mem_router.sv
verif/tile_mem_router_chk.sv
verif/tile_mem_router_tb.sv

// ==== verif/tile_mem_router_chk.sv ====
/*
 * Handshake checker bound to the tile memory router
 */

`include "tile_mem_defines.svh"

module tile_mem_router_chk
  import tile_mem_pkg::*;
  (
    input  logic        clk_i
    , input  logic        rst_n_i
    , input  logic        mem_resp_v_o
    , input  logic        mem_resp_yumi_i
    , input  mem_opcode_e mem_resp_opcode_o
    , input  logic [31:0] mem_resp_addr_o
    , input  logic [63:0] mem_resp_data_o
    , input  logic        cache_resp_v_i
    , input  logic        cache_resp_yumi_o
    , input  logic        cache_cmd_v_o
    , input  logic [31:0] cache_cmd_addr_o
  );
  timeunit 1ns;
  timeprecision 100ps;

  // A newly arriving cache response may take over the output
  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_v_o && !mem_resp_yumi_i |=> mem_resp_v_o && ($rose(cache_resp_v_i)
    || ($stable(mem_resp_opcode_o) && $stable(mem_resp_addr_o) && $stable(mem_resp_data_o))))
    else $error("response changed before it was acknowledged");

  // Cache path only sees yumi for its own valid response
  yumi_needs_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cache_resp_yumi_o |-> cache_resp_v_i && mem_resp_yumi_i)
    else $error("cache path acknowledged without a valid granted response");

  cache_only_cacheable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cache_cmd_v_o |-> cache_cmd_addr_o >= `LOCAL_LIMIT)
    else $error("local address sent to the cache path");

endmodule

bind tile_mem_router tile_mem_router_chk chk (.*);

// ==== verif/tile_mem_router_tb.sv ====
/*
 * Testbench for the tile local memory-map router
 * Random commands checked against a model of both slices and an L2 path model
 */

`include "tile_mem_defines.svh"

module tile_mem_router_tb
  import tile_mem_pkg::*;
  ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ROUTE = 200;
  localparam int N_CFG   = 100;
  localparam int N_CLINT = 100;
  localparam int N_ARB   = 150;
  localparam int N_BP    = 8;
  localparam int N_TOTAL = N_ROUTE + N_CFG + N_CLINT + N_ARB + N_BP;
  localparam logic [63:0] CACHE_KEY = 64'h5a5a_0000_0000_1234;

  logic clk_i, rst_n_i;
  logic mem_cmd_v_i, mem_cmd_ready_o, mem_resp_v_o, mem_resp_yumi_i;
  mem_opcode_e mem_cmd_opcode_i, mem_resp_opcode_o, cache_cmd_opcode_o, cache_resp_opcode_i;
  logic [31:0] mem_cmd_addr_i, mem_resp_addr_o, cache_cmd_addr_o, cache_resp_addr_i, boot_pc_o;
  logic [63:0] mem_cmd_data_i, mem_resp_data_o, cache_cmd_data_o, cache_resp_data_i;
  logic cache_cmd_v_o, cache_cmd_ready_i, cache_resp_v_i, cache_resp_yumi_o;
  logic freeze_o, rtc_tick_i, timer_irq_o, software_irq_o;
  logic yumi_en;

  integer seed, errors, checks, n_resp, n_overlap, cmds_left, mode, yumi_pct, err_mark;
  integer ovl_mark;
  // Reference model state
  mem_msg_s cache_q[$];
  mem_msg_s cfg_exp, clint_exp;
  logic cfg_pend, clint_pend, m_freeze, m_msip, exp_tirq;
  logic [31:0] m_boot_pc;
  logic [63:0] m_mtime, m_cmp;

  // Same-cycle acknowledge
  assign mem_resp_yumi_i = yumi_en & mem_resp_v_o;

  tile_mem_router tile_mem_router_i (.*);

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic make_cmd();
    logic [31:0] r;
    logic [31:0] a;
    logic [63:0] d;
    logic [19:0] ofs;
    logic [3:0] dev;
    integer tgt;
    r = $random(seed);
    d = {$random(seed), $random(seed)};
    if (r[0])
      d = d & 64'h3f;
    case (mode)
      1: tgt = 1;
      2: tgt = 2;
      4: tgt = 1 + r[1];
      default: tgt = r[3:2];
    endcase
    ofs = $random(seed);
    dev = $random(seed);
    if (tgt == 1)
      ofs = (r[5:4] == 0) ? `CFG_FREEZE_OFS : (r[5:4] == 1) ? `CFG_BOOT_PC_OFS : ofs;
    if (tgt == 2)
      ofs = (r[5:4] == 0) ? `CLINT_MSIP_OFS : (r[5:4] == 1) ? `CLINT_MTIMECMP_OFS :
            (r[5:4] == 2) ? `CLINT_MTIME_OFS : ofs;
    if (dev == `CFG_DEV_ID || dev == `CLINT_DEV_ID)
      dev = 4'h7;
    case (tgt)
      0: a = `LOCAL_LIMIT | $random(seed);
      1: a = {8'h0, `CFG_DEV_ID, ofs};
      2: a = {8'h0, `CLINT_DEV_ID, ofs};
      default: a = {1'b0, r[12:6], dev, ofs};
    endcase
    mem_cmd_v_i      <= 1'b1;
    mem_cmd_opcode_i <= mem_opcode_e'(r[8]);
    mem_cmd_addr_i   <= a;
    mem_cmd_data_i   <= d;
  endtask

  always @(posedge clk_i)
  begin : model
    mem_msg_s exp;
    logic [19:0] ofs;
    logic [3:0] dev;
    logic is_wr, wr_mtime, next_tirq;
    logic [31:0] r;
    if (rst_n_i)
    begin
      wr_mtime = 1'b0;
      next_tirq = (m_mtime >= m_cmp);
      check_val("timer_irq_o", timer_irq_o, exp_tirq);
      check_val("software_irq_o", software_irq_o, m_msip);
      check_val("freeze_o", freeze_o, m_freeze);
      check_val("boot_pc_o", boot_pc_o, m_boot_pc);
      check_val("mem_resp_v_o", mem_resp_v_o, cache_resp_v_i | cfg_pend | clint_pend);
      check_val("mem_cmd_ready_o", mem_cmd_ready_o, cache_cmd_ready_i & ~cfg_pend & ~clint_pend);
      check_val("cache_resp_yumi_o", cache_resp_yumi_o, cache_resp_v_i & mem_resp_yumi_i);
      if (int'(cache_resp_v_i) + int'(cfg_pend) + int'(clint_pend) > 1)
        n_overlap++;
      // Responses leave in priority order cache, cfg, clint
      if (mem_resp_v_o && mem_resp_yumi_i)
      begin
        n_resp++;
        if (cache_resp_v_i)
          exp = cache_q.pop_front();
        else if (cfg_pend)
          exp = cfg_exp;
        else
          exp = clint_exp;
        if (!cache_resp_v_i && cfg_pend)
          cfg_pend = 1'b0;
        else if (!cache_resp_v_i)
          clint_pend = 1'b0;
        check_val("mem_resp_opcode_o", mem_resp_opcode_o, exp.opcode);
        check_val("mem_resp_addr_o", mem_resp_addr_o, exp.addr.raw);
        check_val("mem_resp_data_o", mem_resp_data_o, exp.data);
      end
      if (mem_cmd_v_i && mem_cmd_ready_o)
      begin
        ofs = mem_cmd_addr_i[19:0];
        dev = mem_cmd_addr_i[23:20];
        is_wr = (mem_cmd_opcode_i == e_mem_wr);
        exp = '{opcode: mem_cmd_opcode_i, addr: mem_cmd_addr_i, data: '0};
        check_val("cache_cmd_v_o", cache_cmd_v_o, mem_cmd_addr_i >= `LOCAL_LIMIT);
        if (mem_cmd_addr_i >= `LOCAL_LIMIT)
        begin
          check_val("cache_cmd_opcode_o", cache_cmd_opcode_o, mem_cmd_opcode_i);
          check_val("cache_cmd_addr_o", cache_cmd_addr_o, mem_cmd_addr_i);
          check_val("cache_cmd_data_o", cache_cmd_data_o, mem_cmd_data_i);
        end
        else if (dev == `CFG_DEV_ID)
        begin
          if (!is_wr)
            exp.data = (ofs == `CFG_FREEZE_OFS) ? {63'h0, m_freeze} :
                       (ofs == `CFG_BOOT_PC_OFS) ? {32'h0, m_boot_pc} : 64'h0;
          else if (ofs == `CFG_FREEZE_OFS)
            m_freeze = mem_cmd_data_i[0];
          else if (ofs == `CFG_BOOT_PC_OFS)
            m_boot_pc = mem_cmd_data_i[31:0];
          cfg_exp = exp;
          cfg_pend = 1'b1;
        end
        else if (dev == `CLINT_DEV_ID)
        begin
          if (!is_wr)
            exp.data = (ofs == `CLINT_MSIP_OFS) ? {63'h0, m_msip} :
                       (ofs == `CLINT_MTIMECMP_OFS) ? m_cmp :
                       (ofs == `CLINT_MTIME_OFS) ? m_mtime : 64'h0;
          else if (ofs == `CLINT_MSIP_OFS)
            m_msip = mem_cmd_data_i[0];
          else if (ofs == `CLINT_MTIMECMP_OFS)
            m_cmp = mem_cmd_data_i;
          else if (ofs == `CLINT_MTIME_OFS)
          begin
            m_mtime = mem_cmd_data_i;
            wr_mtime = 1'b1;
          end
          clint_exp = exp;
          clint_pend = 1'b1;
        end
      end
      if (!wr_mtime && rtc_tick_i)
        m_mtime = m_mtime + 64'd1;
      exp_tirq = next_tirq;
      if (cache_cmd_v_o && cache_cmd_ready_i)
        cache_q.push_back('{opcode: cache_cmd_opcode_o, addr: cache_cmd_addr_o,
                            data: {32'h0, cache_cmd_addr_o} + CACHE_KEY});

      // Drive the next cycle
      r = $random(seed);
      rtc_tick_i        <= r[8];
      cache_cmd_ready_i <= (r[1:0] != 2'd0);
      yumi_en           <= (r[22:16] % 100) < yumi_pct;
      if (cache_resp_v_i && !cache_resp_yumi_o)
        cache_resp_v_i <= 1'b1;
      else if (cache_q.size() > 0 && r[5:4] == 2'd0)
      begin
        cache_resp_v_i      <= 1'b1;
        cache_resp_opcode_i <= cache_q[0].opcode;
        cache_resp_addr_i   <= cache_q[0].addr.raw;
        cache_resp_data_i   <= cache_q[0].data;
      end
      else
        cache_resp_v_i <= 1'b0;
      if (!mem_cmd_v_i || mem_cmd_ready_o)
      begin
        if (cmds_left > 0)
        begin
          make_cmd();
          cmds_left = cmds_left - 1;
        end
        else
          mem_cmd_v_i <= 1'b0;
      end
    end
  end

  task automatic start_cmds(input integer m, input integer n, input integer pct);
    @(negedge clk_i);
    mode = m;
    yumi_pct = pct;
    cmds_left = n;
  endtask

  task automatic wait_cmds();
    while (cmds_left != 0 || mem_cmd_v_i)
      @(negedge clk_i);
  endtask

  task automatic test_done(input string name);
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial
  begin
    #(N_TOTAL * 40 * 4);
    $display("Run timed out before all commands and responses completed");
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    seed = 32'h2e46c26d;
    {errors, checks, n_resp, n_overlap, cmds_left, mode, err_mark} = '0;
    yumi_pct = 70;
    rst_n_i = 1'b0;
    {mem_cmd_v_i, cache_cmd_ready_i, cache_resp_v_i, rtc_tick_i, yumi_en} = '0;
    mem_cmd_opcode_i = e_mem_rd;
    cache_resp_opcode_i = e_mem_rd;
    {mem_cmd_addr_i, cache_resp_addr_i, mem_cmd_data_i, cache_resp_data_i} = '0;
    {cfg_pend, clint_pend, m_msip, exp_tirq} = '0;
    m_freeze = 1'b1;
    m_boot_pc = `BOOT_PC_RESET;
    m_mtime = '0;
    m_cmp = '1;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("freeze_o", freeze_o, 1'b1);
    check_val("boot_pc_o", boot_pc_o, `BOOT_PC_RESET);
    start_cmds(0, N_ROUTE, 70);
    wait_cmds();
    test_done("routing");
    start_cmds(1, N_CFG, 70);
    wait_cmds();
    test_done("config registers");
    start_cmds(2, N_CLINT, 70);
    wait_cmds();
    test_done("clint");
    ovl_mark = n_overlap;
    start_cmds(3, N_ARB, 15);
    wait_cmds();
    if (n_overlap == ovl_mark)
    begin
      errors++;
      $display("Arbitration test never had two response sources valid at once");
    end
    test_done("arbitration");
    start_cmds(4, N_BP, 0);
    repeat (40) @(negedge clk_i);
    check_val("mem_resp_v_o", mem_resp_v_o, 1'b1);
    check_val("mem_cmd_ready_o", mem_cmd_ready_o, 1'b0);
    yumi_pct = 100;
    wait_cmds();
    while (cache_q.size() != 0 || cfg_pend || clint_pend)
      @(negedge clk_i);
    test_done("back-pressure");
    $display("checks %0d, responses %0d, overlaps %0d, errors %0d",
             checks, n_resp, n_overlap, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
